// ==== Makefile ====
# Verilator build for the streaming FIR filter.

TOP = firFilterTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation finished cleanly"

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
verilog/firConfigPkg.sv
verilog/firCtrlPkg.sv
verilog/firCtrlIf.sv
verilog/firSequencer.sv
verilog/coeffBank.sv
verilog/sampleDelayLine.sv
verilog/tapAccumulator.sv
verilog/firFilterTop.sv
verif/firFilter_properties.sv
verif/firFilterTb.sv

// ==== verif/firFilterTb.sv ====
/*
 * Streaming FIR filter testbench.
 * Drives seeded random coefficient loads and sample streams into the
 * filter and predicts every result with a convolution model. Each
 * result is checked for its value and its latency, and every accepted
 * sample must produce exactly one result.
 */

`timescale 1ns/1ps
`default_nettype none

module firFilterTb;

	import firConfigPkg::*;
	import firCtrlPkg::*;

	localparam int Seed = 30924;
	localparam int ClockPeriod = 40;
	localparam int DriveDelay = 2;
	localparam int TimeoutCycles = 200;
	localparam int StreamSamples = 300;

	logic clock;
	logic rst;
	logic loadStart;
	logic coeffValid;
	sample_t coeffIn;
	logic sampleValid;
	sample_t sampleIn;
	logic halt;
	logic ready;
	result_t resultOut;
	logic resultValid;

	// Model state. Coefficients are kept in load order, history newest first.
	seqState_t modelState;
	int pendingCoeffs[$];
	int modelCoeffs[$];
	int history[$];
	longint expectedQueue[$];
	longint expectedCycle[$];
	longint cycleCount;

	firFilterTop dut_i (
		.clock       (clock),
		.rst         (rst),
		.loadStart   (loadStart),
		.coeffValid  (coeffValid),
		.coeffIn     (coeffIn),
		.sampleValid (sampleValid),
		.sampleIn    (sampleIn),
		.halt        (halt),
		.ready       (ready),
		.resultOut   (resultOut),
		.resultValid (resultValid)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(ClockPeriod / 2) clock = ~clock;
		end
	end

	// After rising edge E the counter reads E.
	always @(posedge clock) begin
		cycleCount <= cycleCount + 64'd1;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic checkValue(input string name, input longint expected, input longint actual);
		if (expected !== actual) begin
			failRun($sformatf("Fail at %0t: %s expected %0d, actual %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic clearModelHistory();
		history.delete();
		for (int k = 0; k < NumTaps; k++) begin
			history.push_back(0);
		end
	endtask

	// Sum of c[k] times x[n-k] over all taps, at full precision.
	function automatic longint convolve();
		longint sum;
		sum = 0;
		for (int k = 0; k < NumTaps; k++) begin
			sum += longint'(modelCoeffs[k]) * longint'(history[k]);
		end
		return sum;
	endfunction

	// Drives one cycle of inputs and applies the same cycle to the model.
	// A load wins over a halt, and either one drops data strobes of that cycle.
	task automatic stepCycle(input logic ls, input logic cv, input sample_t ci,
			input logic sv, input sample_t si, input logic h);
		loadStart = ls;
		coeffValid = cv;
		coeffIn = ci;
		sampleValid = sv;
		sampleIn = si;
		halt = h;
		if (ls) begin
			modelState = LoadCoeff;
			pendingCoeffs.delete();
			clearModelHistory();
		end else if (h && modelState != Idle) begin
			modelState = Idle;
			clearModelHistory();
		end else if (cv && modelState == LoadCoeff) begin
			pendingCoeffs.push_back(int'(ci));
			if (pendingCoeffs.size() == NumTaps) begin
				modelCoeffs = pendingCoeffs;
				modelState = Run;
			end
		end else if (sv && modelState == Run) begin
			history.push_front(int'(si));
			void'(history.pop_back());
			expectedQueue.push_back(convolve());
			// The sample is taken at the next edge and its result shows two edges later.
			expectedCycle.push_back(cycleCount + 64'd2);
		end
		@(posedge clock);
		#(DriveDelay);
		checkValue("ready", longint'(modelState == Run), longint'(ready));
	endtask

	task automatic idleCycle();
		stepCycle(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
	endtask

	task automatic waitReady();
		int waited;
		waited = 0;
		while (ready !== 1'b1) begin
			if (waited == TimeoutCycles) begin
				failRun("Timed out waiting for ready to rise.");
			end else begin
				idleCycle();
				waited++;
			end
		end
	endtask

	// Every accepted sample has produced its result once the queue drains.
	task automatic waitResults();
		int waited;
		waited = 0;
		while (expectedQueue.size() != 0) begin
			if (waited == TimeoutCycles) begin
				failRun("Timed out waiting for resultValid on a pending sample.");
			end else begin
				idleCycle();
				waited++;
			end
		end
	endtask

	// Loads a random set with random gaps. Stray samples during the load must be dropped.
	task automatic loadCoeffs();
		int loaded;
		loaded = 0;
		stepCycle(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
		while (loaded < NumTaps) begin
			if ($urandom_range(3) != 0) begin
				stepCycle(1'b0, 1'b1, sample_t'($urandom), 1'($urandom_range(1)),
					sample_t'($urandom), 1'b0);
				loaded++;
			end else begin
				stepCycle(1'b0, 1'b0, '0, 1'($urandom_range(1)), sample_t'($urandom), 1'b0);
			end
		end
		waitReady();
	endtask

	// Sends samples on random cycles. Idle cycles may carry a stray coeffValid.
	task automatic streamSamples(input int count);
		int sent;
		sent = 0;
		while (sent < count) begin
			if ($urandom_range(2) != 0) begin
				stepCycle(1'b0, 1'b0, '0, 1'b1, sample_t'($urandom), 1'b0);
				sent++;
			end else begin
				stepCycle(1'b0, 1'($urandom_range(1)), sample_t'($urandom), 1'b0, '0, 1'b0);
			end
		end
	endtask

	// Results are sampled at the falling edge, where they are stable.
	initial begin
		forever begin
			@(negedge clock);
			if (!rst && resultValid) begin
				if (expectedQueue.size() == 0) begin
					failRun("A result appeared without an accepted sample.");
				end else begin
					checkValue("resultOut", expectedQueue.pop_front(), longint'(resultOut));
					checkValue("resultCycle", expectedCycle.pop_front(), cycleCount);
				end
			end
		end
	end

	initial begin
		void'($urandom(Seed));
		rst = 1'b1;
		loadStart = 1'b0;
		coeffValid = 1'b0;
		coeffIn = '0;
		sampleValid = 1'b0;
		sampleIn = '0;
		halt = 1'b0;
		cycleCount = 0;
		modelState = Idle;
		clearModelHistory();
		for (int k = 0; k < NumTaps; k++) begin
			modelCoeffs.push_back(0);
		end
		repeat (4) @(posedge clock);
		#(DriveDelay);
		rst = 1'b0;

		// Outputs start at zero, and strobes before any load are ignored.
		checkValue("ready", 0, longint'(ready));
		checkValue("resultValid", 0, longint'(resultValid));
		checkValue("resultOut", 0, longint'(resultOut));
		repeat (8) begin
			stepCycle(1'b0, 1'($urandom_range(1)), sample_t'($urandom),
				1'($urandom_range(1)), sample_t'($urandom), 1'b0);
		end

		// An impulse reproduces the coefficients in load order.
		loadCoeffs();
		stepCycle(1'b0, 1'b0, '0, 1'b1, sample_t'(1), 1'b0);
		repeat (NumTaps) begin
			stepCycle(1'b0, 1'b0, '0, 1'b1, '0, 1'b0);
		end
		waitResults();

		// Long random stream with back-to-back samples.
		streamSamples(StreamSamples);
		waitResults();

		// Halt in the middle of a stream, then reload with a fresh set.
		streamSamples(20);
		stepCycle(1'b0, 1'b0, '0, 1'b1, sample_t'($urandom), 1'b1);
		streamSamples(5);
		waitResults();
		loadCoeffs();
		streamSamples(40);
		waitResults();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/firFilter_properties.sv ====
/*
 * FIR filter handshake properties.
 * Bound into the filter top level. Checks the result latency against
 * accepted samples and the ready flag after reset and after a halt.
 */

`timescale 1ns/1ps
`default_nettype none

module firFilterProperties (
	input logic clock,
	input logic rst,
	input logic loadStart,
	input logic sampleValid,
	input logic halt,
	input logic ready,
	input logic resultValid
);

	// A sample is taken only while running, and never with a load or a halt.
	logic accepted;

	assign accepted = sampleValid && ready && !loadStart && !halt;

	// Every accepted sample yields a result two cycles later.
	assert property (@(posedge clock) disable iff (rst) accepted |-> ##2 resultValid)
		else $error("resultValid missing two cycles after an accepted sample");

	// No result appears without a sample accepted two cycles before.
	assert property (@(posedge clock) disable iff (rst) resultValid |-> $past(accepted, 2))
		else $error("resultValid without an accepted sample two cycles before");

	// The first cycle out of reset is never ready.
	assert property (@(posedge clock) $fell(rst) |-> !ready)
		else $error("ready high on the first cycle after reset");

	// A halt that is not overridden by a load drops ready.
	assert property (@(posedge clock) disable iff (rst) (halt && !loadStart) |=> !ready)
		else $error("ready still high after a halt");

	// A lone sample gives a single-cycle result.
	assert property (@(posedge clock) disable iff (rst)
		($past(accepted, 3) && !$past(accepted, 2)) |-> !resultValid)
		else $error("resultValid stretched over two cycles for a single sample");

endmodule

bind firFilterTop firFilterProperties properties_i (
	.clock       (clock),
	.rst         (rst),
	.loadStart   (loadStart),
	.sampleValid (sampleValid),
	.halt        (halt),
	.ready       (ready),
	.resultValid (resultValid)
);

`default_nettype wire

// ==== verilog/coeffBank.sv ====
/*
 * Coefficient bank.
 * A shift register of NumTaps signed coefficients. Each load pushes
 * the new coefficient in at index 0, so the first coefficient loaded
 * ends up at the top index once the set is complete.
 */

`timescale 1ns/1ps
`default_nettype none

module coeffBank (
	input  logic clock,
	input  logic rst,
	input  firConfigPkg::sample_t coeffIn,
	firCtrlIf.datapath ctrlBus,
	output firConfigPkg::sample_t coeffs [firConfigPkg::NumTaps]
);

	import firConfigPkg::*;

	// After a full load, index k holds c[NumTaps-1-k].
	// The accumulator undoes this reversal when it pairs taps with samples.
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int k = 0; k < NumTaps; k++) begin
				coeffs[k] <= '0;
			end
		end else if (ctrlBus.coeffShift) begin
			// Move every coefficient one place up.
			for (int k = NumTaps - 1; k > 0; k--) begin
				coeffs[k] <= coeffs[k-1];
			end
			coeffs[0] <= coeffIn;
		end
	end

	// The bank is not touched by a halt or a history clear.
	// A coefficient set stays in place until a new load overwrites it.

endmodule

`default_nettype wire

// ==== verilog/firConfigPkg.sv ====
/*
 * FIR datapath configuration.
 * Holds the sample and coefficient width, the filter length and the
 * widths derived from them, together with the signed vector types
 * that the datapath blocks share.
 */

`default_nettype none

package firConfigPkg;

	// Samples and coefficients share one signed width.
	localparam int DataWidth = 8;

	// Number of taps in the filter.
	localparam int NumTaps = 16;

	// A single signed product needs the sum of both operand widths.
	localparam int ProductWidth = 2 * DataWidth;

	// Summing NumTaps products adds log2 of NumTaps bits, so the sum never overflows.
	localparam int ResultWidth = ProductWidth + $clog2(NumTaps);

	typedef logic signed [DataWidth-1:0] sample_t;
	typedef logic signed [ProductWidth-1:0] product_t;
	typedef logic signed [ResultWidth-1:0] result_t;

endpackage

`default_nettype wire

// ==== verilog/firCtrlIf.sv ====
/*
 * FIR control bus.
 * Carries the single-cycle control pulses from the sequencer to the
 * coefficient bank, the sample delay line and the tap accumulator.
 */

`timescale 1ns/1ps
`default_nettype none

interface firCtrlIf;

	// Shift a new coefficient into the bank.
	logic coeffShift;

	// Shift a new sample into the delay line.
	logic sampleShift;

	// Zero the sample history.
	logic clearHistory;

	// Register a new filter result, one cycle after sampleShift.
	logic accumStrobe;

	// The sequencer drives every pulse.
	modport ctrl (
		output coeffShift,
		output sampleShift,
		output clearHistory,
		output accumStrobe
	);

	// Each datapath block reads the pulses it needs.
	modport datapath (
		input coeffShift,
		input sampleShift,
		input clearHistory,
		input accumStrobe
	);

endinterface

`default_nettype wire

// ==== verilog/firCtrlPkg.sv ====
/*
 * FIR control definitions.
 * Holds the sequencer state encoding and the width of the counter
 * that tracks how many coefficients have been loaded.
 */

`default_nettype none

package firCtrlPkg;

	// The sequencer idles, loads a coefficient set, then filters.
	typedef enum logic [1:0] {
		Idle,
		LoadCoeff,
		Run
	} seqState_t;

	// The counter must be able to represent NumTaps itself.
	localparam int CountWidth = $clog2(firConfigPkg::NumTaps + 1);

	// Count value seen while the final coefficient is being loaded.
	localparam logic [CountWidth-1:0] LastCoeffCount = CountWidth'(firConfigPkg::NumTaps - 1);

endpackage

`default_nettype wire

// ==== verilog/firFilterTop.sv ====
/*
 * Streaming FIR filter.
 * Connects the sequencer to the coefficient bank, the sample delay
 * line and the tap accumulator through the control bus, and exposes
 * the strobe handshakes on plain ports.
 */

`timescale 1ns/1ps
`default_nettype none

module firFilterTop (
	input  logic clock,
	input  logic rst,
	input  logic loadStart,
	input  logic coeffValid,
	input  firConfigPkg::sample_t coeffIn,
	input  logic sampleValid,
	input  firConfigPkg::sample_t sampleIn,
	input  logic halt,
	output logic ready,
	output firConfigPkg::result_t resultOut,
	output logic resultValid
);

	import firConfigPkg::*;

	// Coefficient and sample arrays feeding the accumulator.
	sample_t coeffArray [NumTaps];
	sample_t sampleArray [NumTaps];

	firCtrlIf ctrlBus ();

	firSequencer sequencer_i (
		.clock       (clock),
		.rst         (rst),
		.loadStart   (loadStart),
		.coeffValid  (coeffValid),
		.sampleValid (sampleValid),
		.halt        (halt),
		.ready       (ready),
		.ctrlBus     (ctrlBus.ctrl)
	);

	coeffBank coeffBank_i (
		.clock   (clock),
		.rst     (rst),
		.coeffIn (coeffIn),
		.ctrlBus (ctrlBus.datapath),
		.coeffs  (coeffArray)
	);

	sampleDelayLine delayLine_i (
		.clock    (clock),
		.rst      (rst),
		.sampleIn (sampleIn),
		.ctrlBus  (ctrlBus.datapath),
		.samples  (sampleArray)
	);

	tapAccumulator accumulator_i (
		.clock       (clock),
		.rst         (rst),
		.coeffs      (coeffArray),
		.samples     (sampleArray),
		.ctrlBus     (ctrlBus.datapath),
		.resultOut   (resultOut),
		.resultValid (resultValid)
	);

endmodule

`default_nettype wire

// ==== verilog/firSequencer.sv ====
/*
 * FIR sequencer.
 * Tracks whether the filter is idle, loading coefficients or running,
 * counts the coefficient loads, filters out strobes that are illegal
 * in the current state and issues the datapath control pulses.
 */

`timescale 1ns/1ps
`default_nettype none

module firSequencer (
	input  logic clock,
	input  logic rst,
	input  logic loadStart,
	input  logic coeffValid,
	input  logic sampleValid,
	input  logic halt,
	output logic ready,
	firCtrlIf.ctrl ctrlBus
);

	import firCtrlPkg::*;

	seqState_t state;
	logic [CountWidth-1:0] coeffCount;

	// A halt only has an effect once the filter has left Idle.
	logic haltActive;

	// Any strobe that restarts or stops the filter takes priority over data strobes.
	logic abortCycle;

	assign haltActive = halt && (state != Idle);
	assign abortCycle = loadStart || haltActive;

	// Coefficients are only taken while loading, and never in a cycle that restarts
	// or stops the load.
	assign ctrlBus.coeffShift = coeffValid && (state == LoadCoeff) && !abortCycle;

	// Samples are only taken while running. A sample arriving with a halt or a new load
	// is dropped, so no result is built from history that is being cleared.
	assign ctrlBus.sampleShift = sampleValid && (state == Run) && !abortCycle;

	// History is cleared both when a new load starts and when a running or loading
	// filter is halted.
	assign ctrlBus.clearHistory = abortCycle;

	// The filter accepts samples exactly while it is in Run.
	assign ready = (state == Run);

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= Idle;
			coeffCount <= '0;
		end else if (loadStart) begin
			// A new load is accepted in every state and wins over a halt.
			state <= LoadCoeff;
			coeffCount <= '0;
		end else if (haltActive) begin
			state <= Idle;
			coeffCount <= '0;
		end else begin
			case (state)
				Idle: begin
					coeffCount <= '0;
				end
				LoadCoeff: begin
					if (ctrlBus.coeffShift) begin
						// The last coefficient completes the set and starts filtering.
						if (coeffCount == LastCoeffCount) begin
							state <= Run;
							coeffCount <= '0;
						end else begin
							coeffCount <= coeffCount + CountWidth'(1);
						end
					end
				end
				Run: begin
					coeffCount <= '0;
				end
				default: begin
					state <= Idle;
					coeffCount <= '0;
				end
			endcase
		end
	end

	// The accumulator samples the delay line one cycle after it has shifted,
	// so the newest sample is part of the sum.
	always_ff @(posedge clock) begin
		if (rst) begin
			ctrlBus.accumStrobe <= 1'b0;
		end else begin
			ctrlBus.accumStrobe <= ctrlBus.sampleShift;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sampleDelayLine.sv ====
/*
 * Sample delay line.
 * A shift register holding the newest NumTaps signed samples, with
 * the newest one at index 0. A clear zeroes the whole history.
 */

`timescale 1ns/1ps
`default_nettype none

module sampleDelayLine (
	input  logic clock,
	input  logic rst,
	input  firConfigPkg::sample_t sampleIn,
	firCtrlIf.datapath ctrlBus,
	output firConfigPkg::sample_t samples [firConfigPkg::NumTaps]
);

	import firConfigPkg::*;

	// Index k holds x[n-k], where x[n] is the most recent sample.
	always_ff @(posedge clock) begin
		if (rst || ctrlBus.clearHistory) begin
			// A cleared line behaves as if only zeros had ever arrived.
			for (int k = 0; k < NumTaps; k++) begin
				samples[k] <= '0;
			end
		end else if (ctrlBus.sampleShift) begin
			// Age every sample by one position.
			for (int k = NumTaps - 1; k > 0; k--) begin
				samples[k] <= samples[k-1];
			end
			samples[0] <= sampleIn;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tapAccumulator.sv ====
/*
 * Tap accumulator.
 * Multiplies every sample in the delay line with its coefficient,
 * sums all products at full precision and registers the sum with a
 * one-cycle valid strobe. Nothing is rounded or saturated.
 */

`timescale 1ns/1ps
`default_nettype none

module tapAccumulator (
	input  logic clock,
	input  logic rst,
	input  firConfigPkg::sample_t coeffs [firConfigPkg::NumTaps],
	input  firConfigPkg::sample_t samples [firConfigPkg::NumTaps],
	firCtrlIf.datapath ctrlBus,
	output firConfigPkg::result_t resultOut,
	output logic resultValid
);

	import firConfigPkg::*;

	product_t products [NumTaps];
	result_t tapSum;

	// Sample x[n-k] sits at samples[k] and its coefficient c[k] sits at the
	// mirrored bank index, because the bank fills from index 0 upward.
	// Both operands are sign extended to the product width before they are multiplied.
	always_comb begin
		for (int k = 0; k < NumTaps; k++) begin
			products[k] = product_t'(samples[k]) * product_t'(coeffs[NumTaps-1-k]);
		end
	end

	// Each product is sign extended to the full result width before it is added.
	always_comb begin
		tapSum = '0;
		for (int k = 0; k < NumTaps; k++) begin
			tapSum = tapSum + result_t'(products[k]);
		end
	end

	// The result is held until the next strobe replaces it.
	always_ff @(posedge clock) begin
		if (rst) begin
			resultOut <= '0;
		end else if (ctrlBus.accumStrobe) begin
			resultOut <= tapSum;
		end
	end

	// The valid flag is high for exactly one cycle per strobe.
	always_ff @(posedge clock) begin
		if (rst) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= ctrlBus.accumStrobe;
		end
	end

endmodule

`default_nettype wire
